//--- rtl/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // --------------------
  // payload widths
  // --------------------

  // one beat of payload is the full LFSR state
  typedef logic [15:0] word_t;

  // index of a beat inside its frame
  typedef logic [7:0] seq_t;

  // frame length in beats, zero is read as one
  typedef logic [7:0] len_t;

  // LFSR start value, zero is read as one because zero locks the register
  typedef logic [15:0] seed_t;

  // Galois tap mask for x^16 + x^14 + x^13 + x^11 + 1
  localparam word_t LfsrTaps = 16'hB400;

  // --------------------
  // bundles
  // --------------------

  // the parity bit makes the data word plus parity even
  typedef struct packed {
    seq_t  seq;
    word_t data;
    logic  parity;
  } beat_t;

  typedef struct packed {
    seed_t seed;
    len_t  len;
  } cmd_t;

endpackage

`default_nettype wire

//--- rtl/dmr_pkg.sv
`default_nettype none

package dmr_pkg;

  // --------------------
  // redundancy
  // --------------------

  // number of lockstep cores behind the join
  localparam int unsigned NumCores = 2;

  // one bit per core, used for valid, ready and fault lines
  typedef logic [NumCores-1:0] core_vec_t;

  // --------------------
  // error accounting
  // --------------------

  // detected error cycles, saturating
  typedef logic [7:0] err_count_t;

  // the counter stops here instead of wrapping to zero
  localparam err_count_t ErrCountMax = 8'hFF;

endpackage

`default_nettype wire

//--- rtl/frame_gen.sv
`timescale 1ns/1ps
`default_nettype none

module frame_gen
  import stream_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  start_i,
  input  wire cmd_t  cmd_i,
  input  wire logic  hold_i,
  input  wire logic  fault_i,
  input  wire logic  ready_i,
  output logic       valid_o,
  output beat_t      beat_o,
  output logic       idle_o
);

  logic  busy_q;
  word_t lfsr_q;
  word_t lfsr_next;
  seq_t  seq_q;
  len_t  remain_q;
  logic  advance;
  logic  last_beat;

  // a beat only moves on when the join saw no error in this cycle
  assign advance   = busy_q & ready_i & ~hold_i;
  assign last_beat = (remain_q == len_t'(1));

  // right shifting Galois step, the taps are folded in when a one drops out
  assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);

  // --------------------
  // frame state
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
    end else if (advance && last_beat) begin
      busy_q <= 1'b0;
    end
  end

  // a zero seed or a zero length is bumped to one on load
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      lfsr_q   <= (cmd_i.seed == '0) ? word_t'(1) : word_t'(cmd_i.seed);
      remain_q <= (cmd_i.len == '0) ? len_t'(1) : cmd_i.len;
      seq_q    <= '0;
    end else if (advance) begin
      lfsr_q   <= lfsr_next;
      remain_q <= remain_q - len_t'(1);
      seq_q    <= seq_q + seq_t'(1);
    end
  end

  // --------------------
  // outgoing beat
  // --------------------

  assign valid_o = busy_q;
  assign idle_o  = ~busy_q;

  // parity is taken from the clean word so that an injected flip shows up downstream
  assign beat_o.seq    = seq_q;
  assign beat_o.parity = ^lfsr_q;
  assign beat_o.data   = lfsr_q ^ word_t'(fault_i);

  // the controller must wait for the frame to drain before it restarts a core
  start_only_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q)
    else $error("frame_gen restarted while a frame was running");

endmodule

`default_nettype wire

//--- rtl/dmr_error_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module dmr_error_monitor
  import stream_pkg::*;
  import dmr_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 enable_i,
  input  wire core_vec_t            valid_i,
  input  wire beat_t [NumCores-1:0] beat_i,
  input  wire logic                 join_err_i,
  output logic                      err_before_o,
  output err_count_t                err_count_o
);

  core_vec_t  parity_bad;
  core_vec_t  source_en;
  err_count_t err_count_q;

  // --------------------
  // parity check
  // --------------------

  // with checking off only core 0 feeds the destination, so only it is watched
  always_comb begin
    source_en    = '0;
    source_en[0] = 1'b1;
    if (enable_i) begin
      source_en = '1;
    end
  end

  // a beat that is not valid carries no meaning and is ignored
  always_comb begin
    for (int unsigned i = 0; i < NumCores; i++) begin
      parity_bad[i] = valid_i[i] & (beat_i[i].parity != (^beat_i[i].data));
    end
  end

  assign err_before_o = |(parity_bad & source_en);

  // --------------------
  // error counter
  // --------------------

  // counts every cycle in which the join held its output because of an error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_count_q <= '0;
    end else if (join_err_i && (err_count_q != ErrCountMax)) begin
      err_count_q <= err_count_q + err_count_t'(1);
    end
  end

  assign err_count_o = err_count_q;

endmodule

`default_nettype wire

//--- rtl/dmr_handshake_join.sv
`timescale 1ns/1ps
`default_nettype none

module dmr_handshake_join
  import stream_pkg::*;
  import dmr_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 enable_i,
  // error from upstream and the error seen here
  input  wire logic                 error_before_i,
  output logic                      error_o,
  // redundant sources
  input  wire core_vec_t            valid_i,
  output core_vec_t                 ready_o,
  input  wire beat_t [NumCores-1:0] data_i,
  // single destination
  output logic                      valid_o,
  input  wire logic                 ready_i,
  output beat_t                     data_o
);

  logic  valid_d, valid_q;
  logic  repeat_ready_d, repeat_ready_q;
  beat_t data_d, data_q;

  logic  all_valid;
  logic  valid_agree;
  logic  valid_revoked;
  logic  data_agree;
  logic  dest_hs;
  logic  src_hs;

  // --------------------
  // mismatch detection
  // --------------------

  assign all_valid     = &valid_i;
  assign valid_agree   = all_valid | ~(|valid_i);
  // once a beat was offered the sources may not withdraw it
  assign valid_revoked = valid_q & ~all_valid;

  // data is only meaningful when every source claims a valid beat
  always_comb begin
    data_agree = 1'b1;
    for (int unsigned i = 1; i < NumCores; i++) begin
      if (data_i[i] != data_i[0]) begin
        data_agree = 1'b0;
      end
    end
  end

  // with checking off the join never stalls the cores
  always_comb begin
    error_o = 1'b0;
    if (enable_i) begin
      error_o = error_before_i | ~valid_agree | valid_revoked | (all_valid & ~data_agree);
    end
  end

  // --------------------
  // handshakes
  // --------------------

  assign dest_hs = valid_o & ready_i;
  assign src_hs  = &(ready_o & valid_i) & ~error_o;

  // the destination side follows core 0 directly unless an error forces the held copy
  always_comb begin
    valid_o = valid_i[0];
    data_o  = data_i[0];
    if (enable_i) begin
      if (error_o) begin
        valid_o = valid_q;
        data_o  = data_q;
      end
      // the beat already went out, the sources only have to catch up
      if (repeat_ready_q) begin
        valid_o = 1'b0;
      end
    end
  end

  // repeat ready lets the sources finish a beat the destination took during an error
  // when disabled core 1 still gets ready so it leaves the frame together with core 0
  always_comb begin
    if (enable_i) begin
      ready_o = {NumCores{ready_i | repeat_ready_q}};
    end else begin
      ready_o = {NumCores{ready_i}};
    end
  end

  // --------------------
  // next state
  // --------------------

  // remember what is on the output so an error cycle can replay it
  always_comb begin
    valid_d = valid_o;
    data_d  = data_o;
    if (all_valid && !error_o) begin
      valid_d = 1'b1;
      data_d  = data_i[0];
    end
    if (dest_hs || repeat_ready_q) begin
      valid_d = 1'b0;
    end
    if (!enable_i) begin
      valid_d = 1'b0;
    end
  end

  // set when the destination is done but the sources are not, cleared when they are
  always_comb begin
    repeat_ready_d = repeat_ready_q;
    if (dest_hs && !src_hs) begin
      repeat_ready_d = 1'b1;
    end
    if (src_hs) begin
      repeat_ready_d = 1'b0;
    end
    if (!enable_i) begin
      repeat_ready_d = 1'b0;
    end
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q        <= 1'b0;
      repeat_ready_q <= 1'b0;
    end else begin
      valid_q        <= valid_d;
      repeat_ready_q <= repeat_ready_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  // the replay scheme relies on a destination that keeps ready up once it raised it
  dest_ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_i && !valid_o |=> ready_i)
    else $error("destination dropped ready before a beat was offered");

endmodule

`default_nettype wire

//--- rtl/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl
  import stream_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic cmd_req_i,
  input  wire cmd_t cmd_i,
  output logic      cmd_ack_o,
  output logic      start_o,
  output cmd_t      cmd_o,
  input  wire logic idle_i,
  input  wire logic out_valid_i
);

  typedef enum logic [1:0] {
    IDLE,
    START,
    RUN,
    ACK
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  cmd_t        cmd_q;

  // --------------------
  // sequencing
  // --------------------

  // the frame counts as done once core 0 went idle and the join shows nothing more
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (cmd_req_i) state_d = START;
      START:   state_d = RUN;
      RUN:     if (idle_i && !out_valid_i) state_d = ACK;
      ACK:     if (!cmd_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the command is stable while req is high so it is taken in the idle state
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cmd_req_i) begin
      cmd_q <= cmd_i;
    end
  end

  assign start_o   = (state_q == START);
  assign cmd_o     = cmd_q;
  assign cmd_ack_o = (state_q == ACK);

  // four phase rule, the requester waits for ack before it lets go
  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(cmd_req_i) |-> cmd_ack_o)
    else $error("command req fell before ack was given");

endmodule

`default_nettype wire

//--- rtl/lockstep_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module lockstep_stream_top
  import stream_pkg::*;
  import dmr_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      enable_i,
  // four phase command port
  input  wire logic      cmd_req_i,
  input  wire cmd_t      cmd_i,
  output logic           cmd_ack_o,
  // one cycle bit flips per core
  input  wire core_vec_t fault_i,
  // stream destination
  output logic           valid_o,
  input  wire logic      ready_i,
  output beat_t          beat_o,
  output err_count_t     err_count_o
);

  logic                 start;
  cmd_t                 cmd;
  logic                 core0_idle;
  logic                 join_err;
  logic                 err_before;
  core_vec_t            core_valid;
  core_vec_t            core_ready;
  beat_t [NumCores-1:0] core_beat;

  // --------------------
  // command side
  // --------------------

  frame_ctrl u_frame_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .cmd_ack_o   (cmd_ack_o),
    .start_o     (start),
    .cmd_o       (cmd),
    .idle_i      (core0_idle),
    .out_valid_i (valid_o)
  );

  // --------------------
  // lockstep cores
  // --------------------

  // both cores get the same start and command, the join error holds them together
  frame_gen u_core0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start),
    .cmd_i   (cmd),
    .hold_i  (join_err),
    .fault_i (fault_i[0]),
    .ready_i (core_ready[0]),
    .valid_o (core_valid[0]),
    .beat_o  (core_beat[0]),
    .idle_o  (core0_idle)
  );

  // core 1 is a pure shadow, its idle state is never consulted
  frame_gen u_core1 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start),
    .cmd_i   (cmd),
    .hold_i  (join_err),
    .fault_i (fault_i[1]),
    .ready_i (core_ready[1]),
    .valid_o (core_valid[1]),
    .beat_o  (core_beat[1]),
    .idle_o  ()
  );

  // --------------------
  // checking and join
  // --------------------

  dmr_error_monitor u_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (enable_i),
    .valid_i      (core_valid),
    .beat_i       (core_beat),
    .join_err_i   (join_err),
    .err_before_o (err_before),
    .err_count_o  (err_count_o)
  );

  dmr_handshake_join u_join (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .error_before_i (err_before),
    .error_o        (join_err),
    .valid_i        (core_valid),
    .ready_o        (core_ready),
    .data_i         (core_beat),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .data_o         (beat_o)
  );

endmodule

`default_nettype wire

//--- test/tb_lockstep_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lockstep_stream
  import stream_pkg::*;
  import dmr_pkg::*;
();

  // frames 0 to 11 run clean, the next 36 get faults on either core, the rest run unchecked
  localparam int NumFrames   = 60;
  localparam int CleanFrames = 12;
  localparam int FaultFrames = 36;

  // terms 16, 14, 13 and 11 of the polynomial land one bit below their power
  localparam word_t PolyMask = word_t'((1 << 15) | (1 << 13) | (1 << 12) | (1 << 10));

  logic       clk_i;
  logic       rst_ni;
  logic       enable_i;
  logic       cmd_req_i;
  cmd_t       cmd_i;
  logic       cmd_ack_o;
  core_vec_t  fault_i;
  logic       valid_o;
  logic       ready_i;
  beat_t      beat_o;
  err_count_t err_count_o;

  cmd_t        frame_cmd [NumFrames];
  int          frame_mode [NumFrames];
  err_count_t  exp_count;
  int unsigned watchdog_cycles;
  logic        watchdog_armed;

  always #4 clk_i = ~clk_i;

  lockstep_stream_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .cmd_ack_o   (cmd_ack_o),
    .fault_i     (fault_i),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .beat_o      (beat_o),
    .err_count_o (err_count_o)
  );

  // --------------------
  // reference model
  // --------------------

  // right shifting Galois LFSR, the mask is folded in when a one drops out
  function automatic word_t lfsr_step(input word_t state);
    if (state[0]) begin
      return (state >> 1) ^ PolyMask;
    end
    return state >> 1;
  endfunction

  // a zero length still produces one beat
  function automatic int frame_beats(input len_t len);
    if (len == '0) begin
      return 1;
    end
    return int'(len);
  endfunction

  // --------------------
  // checks
  // --------------------

  task automatic stop_run(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("sim failed");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      stop_run($sformatf("%s expected seq %0d data %h parity %b actual seq %0d data %h parity %b",
        name, exp.seq, exp.data, exp.parity, act.seq, act.data, act.parity));
    end
  endtask

  task automatic check_count(input string name, input err_count_t exp, input err_count_t act);
    if (act !== exp) begin
      stop_run($sformatf("%s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("%s expected %b actual %b", name, exp, act));
    end
  endtask

  // --------------------
  // one command
  // --------------------

  // mode 0 runs clean, mode 1 flips bits on either core, mode 2 runs core 0 alone with core 1 hit
  task automatic run_frame(input cmd_t cmd, input int mode);
    word_t lfsr;
    beat_t exp_beat;
    int    beats;
    int    delivered;
    int    stall_left;
    logic  started;
    logic  acked;
    logic  stalled;
    logic  seen_ready;
    logic  seen_valid;

    lfsr       = (cmd.seed == '0) ? word_t'(1) : word_t'(cmd.seed);
    beats      = frame_beats(cmd.len);
    delivered  = 0;
    stall_left = 0;
    started    = 1'b0;
    acked      = 1'b0;
    stalled    = 1'b0;

    check_flag("cmd_ack_o", 1'b0, cmd_ack_o);
    enable_i  = (mode != 2);
    cmd_i     = cmd;
    cmd_req_i = 1'b1;

    while (!acked) begin
      // values here are the ones the next rising edge will sample
      @(negedge clk_i);
      seen_ready = ready_i;
      seen_valid = valid_o;
      // a stalled beat may not be withdrawn
      if (stalled) begin
        check_flag("valid_o", 1'b1, valid_o);
      end
      if (valid_o) begin
        started = 1'b1;
        if (delivered >= beats) begin
          stop_run("valid_o came up again after the last beat of the frame");
        end
        exp_beat.seq    = seq_t'(delivered);
        exp_beat.data   = lfsr;
        exp_beat.parity = ^lfsr;
        check_beat("beat_o", exp_beat, beat_o);
        if (ready_i) begin
          lfsr      = lfsr_step(lfsr);
          delivered = delivered + 1;
        end
      end
      stalled = valid_o & ~ready_i;
      if (cmd_ack_o) begin
        acked = 1'b1;
        if (delivered != beats) begin
          stop_run($sformatf("beats delivered at cmd_ack_o expected %0d actual %0d",
            beats, delivered));
        end
        check_flag("valid_o", 1'b0, valid_o);
        check_count("err_count_o", exp_count, err_count_o);
      end

      @(posedge clk_i);
      #1;
      // back-pressure comes in stretches of one to six cycles
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
      end else if ($urandom_range(7, 0) == 0) begin
        stall_left = int'($urandom_range(6, 1));
      end
      // once ready is up with nothing offered the destination has to keep it up
      if (seen_ready && !seen_valid) begin
        ready_i = 1'b1;
      end else begin
        ready_i = (stall_left == 0);
      end
      // flips stay clear of the last two beats so the cores are always busy when hit
      fault_i = '0;
      if (mode != 0 && started && (delivered < beats - 2) && ($urandom_range(3, 0) == 0)) begin
        if (mode == 2 || $urandom_range(1, 0) == 1) begin
          fault_i[1] = 1'b1;
        end else begin
          fault_i[0] = 1'b1;
        end
        // every flipped cycle with checking on costs one error cycle, capped at 255
        if (mode == 1 && exp_count != 8'hFF) begin
          exp_count = exp_count + 8'd1;
        end
      end
    end

    // release the request, ack must follow one cycle later
    cmd_req_i = 1'b0;
    fault_i   = '0;
    @(negedge clk_i);
    check_flag("cmd_ack_o", 1'b1, cmd_ack_o);
    check_flag("valid_o", 1'b0, valid_o);
    @(negedge clk_i);
    check_flag("cmd_ack_o", 1'b0, cmd_ack_o);
    check_flag("valid_o", 1'b0, valid_o);
    @(posedge clk_i);
    #1;
  endtask

  // --------------------
  // watchdog
  // --------------------

  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge clk_i);
    stop_run("watchdog expired before all frames had finished");
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int unsigned total_beats;

    void'($urandom(8016));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    enable_i        = 1'b1;
    cmd_req_i       = 1'b0;
    cmd_i           = '0;
    fault_i         = '0;
    ready_i         = 1'b0;
    exp_count       = '0;
    watchdog_armed  = 1'b0;
    watchdog_cycles = 0;
    total_beats     = 0;

    // the first two frames hit the zero seed and zero length corners
    for (int i = 0; i < NumFrames; i++) begin
      frame_cmd[i].seed = seed_t'($urandom_range(16'hFFFF, 0));
      frame_cmd[i].len  = len_t'($urandom_range(40, 0));
      if (i == 0) begin
        frame_cmd[i] = '0;
      end
      if (i == 1) begin
        frame_cmd[i].seed = '0;
      end
      if (i < CleanFrames) begin
        frame_mode[i] = 0;
      end else if (i < CleanFrames + FaultFrames) begin
        frame_mode[i] = 1;
      end else begin
        frame_mode[i] = 2;
      end
      total_beats = total_beats + frame_beats(frame_cmd[i].len);
    end
    watchdog_cycles = total_beats * 40 + 2000;
    watchdog_armed  = 1'b1;

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // nothing is offered or acknowledged straight out of reset
    @(negedge clk_i);
    check_flag("cmd_ack_o", 1'b0, cmd_ack_o);
    check_flag("valid_o", 1'b0, valid_o);
    check_count("err_count_o", 8'd0, err_count_o);
    @(posedge clk_i);
    #1;

    for (int i = 0; i < NumFrames; i++) begin
      run_frame(frame_cmd[i], frame_mode[i]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- lockstep_stream.f
rtl/stream_pkg.sv
rtl/dmr_pkg.sv
rtl/frame_gen.sv
rtl/dmr_error_monitor.sv
rtl/dmr_handshake_join.sv
rtl/frame_ctrl.sv
rtl/lockstep_stream_top.sv
test/tb_lockstep_stream.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_lockstep_stream
FILELIST   := lockstep_stream.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --assert --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only --assert --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
